// File: include/wisc_cfg.svh
// Widths, opcode constants and forwarding codes for the execute slice, included by RTL and testbench
`ifndef WISC_CFG_SVH
`define WISC_CFG_SVH

// Datapath widths
`define WORD_WIDTH      16
`define REG_IDX_WIDTH   3

// Full 5-bit opcodes with special execute handling
`define OP_SLBI         5'b10010
`define OP_LBI          5'b11000
`define OP_BTR          5'b11001
`define OP_JAL          5'b00110
`define OP_JALR         5'b00111

// Opcode classes, matched on the top three opcode bits
`define OP_BRANCH_CLASS 3'b011
`define OP_SET_CLASS    3'b111

// Operand source selects from the forwarding unit
`define FWD_REG         2'd0
`define FWD_MEMWB_ALU   2'd1
`define FWD_EXMEM_ALU   2'd2
`define FWD_MEMWB_DATA  2'd3

`endif

// File: hw/wiscPkg.sv
// Vector types shared by the execute slice RTL and its testbench, used through import wiscPkg::*
`include "wisc_cfg.svh"

package wiscPkg;

    // Data word and register number
    typedef logic [`WORD_WIDTH-1:0]    word_t;
    typedef logic [`REG_IDX_WIDTH-1:0] regIdx_t;

    // Decoded instruction opcode
    typedef logic [4:0] aluOp_t;

    // ALU operation select
    typedef logic [2:0] aluCtl_t;

    // Forwarding mux select, see FWD_* codes
    typedef logic [1:0] fwdSel_t;

    // ALU operation codes
    localparam aluCtl_t ALU_ROL = 3'b000;   // Rotate left
    localparam aluCtl_t ALU_SHL = 3'b001;   // Shift left
    localparam aluCtl_t ALU_ROR = 3'b010;   // Rotate right
    localparam aluCtl_t ALU_SRL = 3'b011;   // Shift right logical
    localparam aluCtl_t ALU_ADD = 3'b100;
    localparam aluCtl_t ALU_AND = 3'b101;
    localparam aluCtl_t ALU_OR  = 3'b110;
    localparam aluCtl_t ALU_XOR = 3'b111;

endpackage

// File: hw/alu.sv
// 16-bit ALU for the execute stage, instantiated once inside execute
`timescale 1ns/10ps

module alu
    import wiscPkg::*;
(
    input  word_t   inA,
    input  word_t   inB,
    input  logic    cIn,
    input  logic    invA,
    input  logic    invB,
    input  logic    sign,
    input  aluCtl_t oper,
    output word_t   out,
    output logic    zero,
    output logic    ofl,
    output logic    ltz
);

    localparam int W = $bits(word_t);

    word_t            opA;
    word_t            opB;
    word_t            addRes;
    logic             addCarry;
    logic             signedOfl;
    logic [3:0]       shAmt;
    logic [2*W-1:0]   rolWide;
    logic [2*W-1:0]   rorWide;

    // Optional inversion ahead of every operation
    assign opA = invA ? ~inA : inA;
    assign opB = invB ? ~inB : inB;

    assign shAmt = opB[3:0];   // Shift amount after inversion

    // Adder with carry in, carry out kept for unsigned overflow
    assign {addCarry, addRes} = opA + opB + cIn;

    // Same-sign operands giving a result of the other sign
    assign signedOfl = (opA[W-1] == opB[W-1]) && (addRes[W-1] != opA[W-1]);

    // Rotates from a doubled word, the wanted half is picked below
    assign rolWide = {opA, opA} << shAmt;
    assign rorWide = {opA, opA} >> shAmt;

    always_comb begin
        case (oper)
            ALU_ROL: out = rolWide[2*W-1:W];
            ALU_SHL: out = opA << shAmt;
            ALU_ROR: out = rorWide[W-1:0];
            ALU_SRL: out = opA >> shAmt;
            ALU_ADD: out = addRes;
            ALU_AND: out = opA & opB;
            ALU_OR:  out = opA | opB;
            ALU_XOR: out = opA ^ opB;
            default: out = addRes;
        endcase
    end

    assign zero = (out == '0);

    // Overflow only means something for the adder
    always_comb begin
        if (oper == ALU_ADD) begin
            ofl = sign ? signedOfl : addCarry;
        end else begin
            ofl = 1'b0;
        end
    end

    // True sign of the sum, corrected when it wrapped
    assign ltz = addRes[W-1] ^ signedOfl;

endmodule

// File: hw/forwardUnit.sv
// Forwarding unit choosing each execute operand source from the register file or a later stage
`timescale 1ns/10ps
`include "wisc_cfg.svh"

module forwardUnit
    import wiscPkg::*;
(
    input  regIdx_t idExRs,
    input  regIdx_t idExRt,
    input  regIdx_t exMemRd,
    input  regIdx_t memWbRd,
    input  logic    exMemRegWrite,
    input  logic    exMemMemRead,
    input  logic    memWbRegWrite,
    input  logic    memWbMemRead,
    output fwdSel_t forwardA,
    output fwdSel_t forwardB
);

    // Priority select for one source register
    function automatic fwdSel_t pickFwd(
        input regIdx_t srcReg,
        input regIdx_t exRd,
        input logic    exWr,
        input logic    exLoad,
        input regIdx_t wbRd,
        input logic    wbWr,
        input logic    wbLoad
    );
        fwdSel_t sel;
        sel = `FWD_REG;
        if (exWr && !exLoad && (exRd == srcReg)) begin
            sel = `FWD_EXMEM_ALU;   // Youngest result wins
        end else if (wbWr && (wbRd == srcReg)) begin
            sel = wbLoad ? `FWD_MEMWB_DATA : `FWD_MEMWB_ALU;
        end
        // Load still in EX/MEM lands here, no stall in this slice
        return sel;
    endfunction

    assign forwardA = pickFwd(idExRs, exMemRd, exMemRegWrite, exMemMemRead,
                              memWbRd, memWbRegWrite, memWbMemRead);
    assign forwardB = pickFwd(idExRt, exMemRd, exMemRegWrite, exMemMemRead,
                              memWbRd, memWbRegWrite, memWbMemRead);

endmodule

// File: hw/execute.sv
// Execute stage with operand forwarding, special operand handling, ALU and result selection
`timescale 1ns/10ps
`include "wisc_cfg.svh"

module execute
    import wiscPkg::*;
(
    input  word_t   readData1,
    input  word_t   readData2,
    input  word_t   immVal,
    input  word_t   pc,
    input  word_t   aluResExMem,
    input  word_t   aluResMemWb,
    input  word_t   memDataMemWb,
    input  aluCtl_t aluControl,
    input  logic    aluSrc,
    input  logic    invA,
    input  logic    invB,
    input  logic    cIn,
    input  logic    sign,
    input  aluOp_t  aluOp,
    input  fwdSel_t forwardA,
    input  fwdSel_t forwardB,
    output word_t   aluRes,
    output word_t   memWriteData,
    output logic    zero,
    output logic    ltz
);

    word_t readData1f;
    word_t readData2f;
    word_t aluInA;
    word_t aluInB;
    word_t aluOut;
    word_t setWord;
    word_t btrOut;
    logic  aluOfl;
    logic  setFlag;
    logic  isSlbi;
    logic  isLbi;
    logic  isBranch;
    logic  isSet;
    logic  isBtr;
    logic  isJmpLnk;

    // One forwarding mux, used for both register operands
    function automatic word_t fwdMux(
        input fwdSel_t sel,
        input word_t   regVal,
        input word_t   exMemVal,
        input word_t   memWbVal,
        input word_t   memWbData
    );
        case (sel)
            `FWD_MEMWB_ALU:  return memWbVal;
            `FWD_EXMEM_ALU:  return exMemVal;
            `FWD_MEMWB_DATA: return memWbData;
            default:         return regVal;
        endcase
    endfunction

    assign readData1f = fwdMux(forwardA, readData1, aluResExMem, aluResMemWb, memDataMemWb);
    assign readData2f = fwdMux(forwardB, readData2, aluResExMem, aluResMemWb, memDataMemWb);

    // Opcode decode for the special cases
    assign isSlbi   = (aluOp == `OP_SLBI);
    assign isLbi    = (aluOp == `OP_LBI);
    assign isBtr    = (aluOp == `OP_BTR);
    assign isJmpLnk = (aluOp == `OP_JAL) || (aluOp == `OP_JALR);
    assign isBranch = (aluOp[4:2] == `OP_BRANCH_CLASS);
    assign isSet    = (aluOp[4:2] == `OP_SET_CLASS);

    // LBI adds the immediate to zero, SLBI to rs shifted up a byte
    assign aluInA = isLbi ? '0 : (isSlbi ? (readData1f << 8) : readData1f);

    // Branches test rs against zero
    assign aluInB = isBranch ? '0 : (aluSrc ? immVal : readData2f);

    assign memWriteData = readData2f;   // Store data follows rt forwarding

    alu aluInst (
        .inA  (aluInA),
        .inB  (aluInB),
        .cIn  (cIn),
        .invA (invA),
        .invB (invB),
        .sign (sign),
        .oper (aluControl),
        .out  (aluOut),
        .zero (zero),
        .ofl  (aluOfl),
        .ltz  (ltz)
    );

    // Set instructions: seq, slt, sle, sco
    always_comb begin
        case (aluOp[1:0])
            2'b00:   setFlag = zero;
            2'b01:   setFlag = ltz;
            2'b10:   setFlag = zero | ltz;
            default: setFlag = aluOfl;
        endcase
    end

    assign setWord = {{(`WORD_WIDTH-1){1'b0}}, setFlag};

    always_comb begin
        for (int i = 0; i < `WORD_WIDTH; i++) begin
            btrOut[i] = readData1f[`WORD_WIDTH-1-i];
        end
    end

    // Later checks override earlier ones
    always_comb begin
        aluRes = aluOut;
        if (isSet) aluRes = setWord;
        if (isBtr) aluRes = btrOut;
        if (isJmpLnk) aluRes = pc;   // Link value for jal and jalr
    end

endmodule

// File: hw/exMemReg.sv
// EX/MEM pipeline register carrying the execute result and memory controls to the next stage
`timescale 1ns/10ps

module exMemReg
    import wiscPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  word_t   aluRes,
    input  word_t   memWriteData,
    input  regIdx_t rd,
    input  logic    regWrite,
    input  logic    memRead,
    input  logic    memWrite,
    output word_t   exMemAluRes,
    output word_t   exMemWriteData,
    output regIdx_t exMemRd,
    output logic    exMemRegWrite,
    output logic    exMemMemRead,
    output logic    exMemMemWrite
);

    // All fields cleared on reset so the first cycles carry a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            exMemAluRes    <= '0;
            exMemWriteData <= '0;
            exMemRd        <= '0;
            exMemRegWrite  <= 1'b0;
            exMemMemRead   <= 1'b0;
            exMemMemWrite  <= 1'b0;
        end else begin
            exMemAluRes    <= aluRes;
            exMemWriteData <= memWriteData;
            exMemRd        <= rd;
            exMemRegWrite  <= regWrite;
            exMemMemRead   <= memRead;
            exMemMemWrite  <= memWrite;
        end
    end

endmodule

// File: hw/exSlice.sv
// Top of the execute slice joining forwarding, execute and the EX/MEM register
`timescale 1ns/10ps

module exSlice
    import wiscPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  word_t   readData1,
    input  word_t   readData2,
    input  word_t   immVal,
    input  word_t   pc,
    input  word_t   aluResMemWb,
    input  word_t   memDataMemWb,
    input  aluCtl_t aluControl,
    input  logic    aluSrc,
    input  logic    invA,
    input  logic    invB,
    input  logic    cIn,
    input  logic    sign,
    input  logic    regWrite,
    input  logic    memRead,
    input  logic    memWrite,
    input  aluOp_t  aluOp,
    input  regIdx_t idExRs,
    input  regIdx_t idExRt,
    input  regIdx_t idExRd,
    input  regIdx_t memWbRd,
    input  logic    memWbRegWrite,
    input  logic    memWbMemRead,
    output logic    zero,
    output logic    ltz,
    output word_t   exMemAluRes,
    output word_t   exMemWriteData,
    output regIdx_t exMemRd,
    output logic    exMemRegWrite,
    output logic    exMemMemRead,
    output logic    exMemMemWrite
);

    fwdSel_t forwardA;
    fwdSel_t forwardB;
    word_t   aluRes;
    word_t   memWriteData;

    forwardUnit fwdInst (
        .idExRs(idExRs), .idExRt(idExRt), .exMemRd(exMemRd), .memWbRd(memWbRd),
        .exMemRegWrite(exMemRegWrite), .exMemMemRead(exMemMemRead),
        .memWbRegWrite(memWbRegWrite), .memWbMemRead(memWbMemRead),
        .forwardA(forwardA), .forwardB(forwardB)
    );

    execute exInst (
        .readData1(readData1), .readData2(readData2), .immVal(immVal), .pc(pc),
        .aluResExMem(exMemAluRes), .aluResMemWb(aluResMemWb), .memDataMemWb(memDataMemWb),
        .aluControl(aluControl), .aluSrc(aluSrc), .invA(invA), .invB(invB), .cIn(cIn),
        .sign(sign), .aluOp(aluOp), .forwardA(forwardA), .forwardB(forwardB),
        .aluRes(aluRes), .memWriteData(memWriteData), .zero(zero), .ltz(ltz)
    );

    exMemReg pipeInst (
        .clk(clk), .rst(rst), .aluRes(aluRes), .memWriteData(memWriteData), .rd(idExRd),
        .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .exMemAluRes(exMemAluRes), .exMemWriteData(exMemWriteData), .exMemRd(exMemRd),
        .exMemRegWrite(exMemRegWrite), .exMemMemRead(exMemMemRead),
        .exMemMemWrite(exMemMemWrite)
    );

endmodule

// File: testbench/exSliceTb.sv
// Self-checking testbench for the execute slice that runs as top module exSliceTb from the file list
`timescale 1ns/10ps
`include "wisc_cfg.svh"

module exSliceTb
    import wiscPkg::*;
;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_RAND     = 300;
    localparam int NUM_FWD      = 100;
    localparam int NUM_SPEC     = 40;
    localparam int NUM_SETBR    = 40;
    localparam int NUM_INSTR    = NUM_RAND + NUM_FWD + NUM_SPEC + NUM_SETBR;
    // One cycle per instruction plus reset, doubled and padded for margin
    localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + NUM_INSTR) + 30;

    logic    clk = 1'b0;
    logic    rst;
    word_t   readData1, readData2, immVal, pc, aluResMemWb, memDataMemWb;
    aluCtl_t aluControl;
    logic    aluSrc, invA, invB, cIn, sign, regWrite, memRead, memWrite;
    aluOp_t  aluOp;
    regIdx_t idExRs, idExRt, idExRd, memWbRd;
    logic    memWbRegWrite, memWbMemRead;
    logic    zero, ltz;
    word_t   exMemAluRes, exMemWriteData;
    regIdx_t exMemRd;
    logic    exMemRegWrite, exMemMemRead, exMemMemWrite;

    logic [31:0] lfsr;
    int          cycleCount = 0;
    int          checkCount = 0, failCount = 0, testChecks = 0, testFails = 0;

    // Model copy of the instruction now sitting in EX/MEM
    regIdx_t prevRd;
    logic    prevRegWrite, prevMemRead;
    word_t   prevRes;

    aluOp_t  specOps [5] = '{`OP_SLBI, `OP_LBI, `OP_BTR, `OP_JAL, `OP_JALR};

    exSlice uut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles before all tests finished", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic stepLfsr();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t randBits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[14:0], stepLfsr()};
        return r;
    endfunction

    task automatic checkVal(input string name, input word_t expVal, input word_t actVal);
        checkCount++;
        testChecks++;
        assert (actVal === expVal) else begin
            failCount++;
            testFails++;
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expVal, actVal);
        end
    endtask

    task automatic endTest(input string name);
        $display("%-12s finished: %0d checks, %0d errors", name, testChecks, testFails);
        testChecks = 0;
        testFails  = 0;
    endtask

    task automatic checkCleared();
        checkVal("exMemRegWrite", 0, exMemRegWrite);
        checkVal("exMemMemRead", 0, exMemMemRead);
        checkVal("exMemMemWrite", 0, exMemMemWrite);
        checkVal("exMemAluRes", 0, exMemAluRes);
        checkVal("exMemWriteData", 0, exMemWriteData);
        checkVal("exMemRd", 0, exMemRd);
    endtask

    // Reference ALU with signed overflow taken from the exact integer sum
    task automatic modelAlu(input word_t a, input word_t b, input logic cin, input logic ia,
                            input logic ib, input logic sgn, input aluCtl_t ctl,
                            output word_t res, output logic z, output logic l, output logic o);
        word_t      x, y;
        logic [16:0] sum;
        int         exact, n;
        x = ia ? ~a : a;
        y = ib ? ~b : b;
        n = y[3:0];
        sum = {1'b0, x} + {1'b0, y} + {16'b0, cin};
        exact = $signed(x) + $signed(y) + int'(cin);
        res = x;
        case (ctl)
            ALU_ROL: repeat (n) res = {res[14:0], res[15]};
            ALU_SHL: res = x << n;
            ALU_ROR: repeat (n) res = {res[0], res[15:1]};
            ALU_SRL: res = x >> n;
            ALU_ADD: res = sum[15:0];
            ALU_AND: res = x & y;
            ALU_OR:  res = x | y;
            default: res = x ^ y;
        endcase
        z = (res == 16'h0000);
        l = (exact < 0);
        o = (ctl != ALU_ADD) ? 1'b0 : (sgn ? (exact > 32767 || exact < -32768) : sum[16]);
    endtask

    // EX/MEM non-load wins over MEM/WB, which wins over the register file
    function automatic word_t fwdModel(input regIdx_t src, input word_t regVal);
        if (prevRegWrite && !prevMemRead && prevRd == src) return prevRes;
        if (memWbRegWrite && memWbRd == src) return memWbMemRead ? memDataMemWb : aluResMemWb;
        return regVal;
    endfunction

    // Flags checked in the issue cycle and EX/MEM after the next edge
    task automatic runInstr();
        word_t a, b, opA, opB, aluOut, expRes;
        logic  z, l, o, flag;
        a = fwdModel(idExRs, readData1);
        b = fwdModel(idExRt, readData2);
        opA = a;
        if (aluOp == `OP_SLBI) opA = {a[7:0], 8'h00};
        if (aluOp == `OP_LBI) opA = '0;
        opB = aluSrc ? immVal : b;
        if (aluOp[4:2] == `OP_BRANCH_CLASS) opB = '0;   // Branch tests rs alone
        modelAlu(opA, opB, cIn, invA, invB, sign, aluControl, aluOut, z, l, o);
        expRes = aluOut;
        if (aluOp[4:2] == `OP_SET_CLASS) begin
            case (aluOp[1:0])
                2'b00:   flag = z;
                2'b01:   flag = l;
                2'b10:   flag = z | l;
                default: flag = o;
            endcase
            expRes = {15'b0, flag};
        end
        if (aluOp == `OP_BTR) begin
            for (int i = 0; i < 16; i++) expRes[15-i] = a[i];
        end
        if (aluOp == `OP_JAL || aluOp == `OP_JALR) expRes = pc;
        @(negedge clk);
        checkVal("zero", z, zero);
        checkVal("ltz", l, ltz);
        @(posedge clk);
        #1;
        checkVal("exMemAluRes", expRes, exMemAluRes);
        checkVal("exMemWriteData", b, exMemWriteData);   // Forwarded rt is the store data
        checkVal("exMemRd", idExRd, exMemRd);
        checkVal("exMemRegWrite", regWrite, exMemRegWrite);
        checkVal("exMemMemRead", memRead, exMemMemRead);
        checkVal("exMemMemWrite", memWrite, exMemMemWrite);
        prevRd = idExRd;
        prevRegWrite = regWrite;
        prevMemRead = memRead;
        prevRes = expRes;
        #1;
    endtask

    // Plain ALU instruction with random fields and no register writers
    task automatic randomInstr();
        readData1 = randBits(16);
        readData2 = randBits(16);
        immVal = randBits(16);
        pc = randBits(16);
        aluResMemWb = randBits(16);
        memDataMemWb = randBits(16);
        aluControl = 3'(randBits(3));
        aluSrc = stepLfsr();
        invA = stepLfsr();
        invB = stepLfsr();
        cIn = stepLfsr();
        sign = stepLfsr();
        aluOp = {3'b010, 2'(randBits(2))};
        idExRs = 3'(randBits(3));
        idExRt = 3'(randBits(3));
        idExRd = 3'(randBits(3));
        memWbRd = 3'(randBits(3));
        memWbMemRead = stepLfsr();
        memWrite = stepLfsr();
        regWrite = 1'b0;
        memRead = 1'b0;
        memWbRegWrite = 1'b0;
    endtask

    initial begin
        lfsr = 32'h92c1aed1;
        prevRd = '0;
        prevRegWrite = 1'b0;
        prevMemRead = 1'b0;
        prevRes = '0;
        rst = 1'b1;
        randomInstr();
        regWrite = 1'b1;   // Controls held high so reset has something to clear
        memRead = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            checkCleared();
            #1;
            randomInstr();
            regWrite = 1'b1;
            memRead = 1'b1;
            memWrite = 1'b1;
        end
        rst = 1'b0;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        @(negedge clk);
        checkCleared();
        endTest("reset");
        @(posedge clk);
        #2;

        for (int i = 0; i < NUM_RAND; i++) begin
            randomInstr();
            runInstr();
        end
        endTest("random ALU");

        // Only registers 0 and 1 so that EX/MEM and MEM/WB matches come often
        for (int i = 0; i < NUM_FWD; i++) begin
            randomInstr();
            idExRs = 3'(randBits(1));
            idExRt = 3'(randBits(1));
            idExRd = 3'(randBits(1));
            memWbRd = 3'(randBits(1));
            regWrite = (2'(randBits(2)) != 2'b00);
            memRead = (2'(randBits(2)) == 2'b00);
            memWbRegWrite = stepLfsr();
            runInstr();
        end
        endTest("forwarding");

        for (int i = 0; i < NUM_SPEC; i++) begin
            randomInstr();
            aluOp = specOps[i % 5];
            regWrite = 1'b1;
            if (i % 5 < 2) begin
                aluSrc = 1'b1;
                aluControl = (i % 5 == 0) ? ALU_OR : ALU_ADD;
                invA = 1'b0;
                invB = 1'b0;
                cIn = 1'b0;
            end
            runInstr();
        end
        endTest("special ops");

        for (int i = 0; i < NUM_SETBR; i++) begin
            randomInstr();
            aluControl = ALU_ADD;
            invA = 1'b0;
            if (i % 2 == 0) begin
                aluOp = {`OP_SET_CLASS, 2'(i / 2)};   // All four set flags in turn
                aluSrc = 1'b0;
                invB = 1'b1;   // rs minus rt
                cIn = 1'b1;
                sign = i[3];   // Signed overflow and carry out both reach the flag
                if (stepLfsr()) readData2 = readData1;
            end else begin
                aluOp = {`OP_BRANCH_CLASS, 2'(randBits(2))};
                invB = 1'b0;
                cIn = 1'b0;
                if (stepLfsr()) readData1 = '0;
            end
            runInstr();
        end
        endTest("set/branch");

        $display("Summary: %0d checks passed, %0d checks failed", checkCount - failCount, failCount);
        if (failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: exSlice.f
+incdir+include
hw/wiscPkg.sv
hw/alu.sv
hw/forwardUnit.sv
hw/execute.sv
hw/exMemReg.sv
hw/exSlice.sv
testbench/exSliceTb.sv

// File: Bender.yml
package:
  name: exSlice

export_include_dirs:
  - include

sources:
  - files:
      - hw/wiscPkg.sv
      - hw/alu.sv
      - hw/forwardUnit.sv
      - hw/execute.sv
      - hw/exMemReg.sv
      - hw/exSlice.sv
  - target: test
    files:
      - testbench/exSliceTb.sv
